//--- src/search_cases.svh
// TLB search case table
`ifndef SEARCH_CASES_SVH
`define SEARCH_CASES_SVH

// page contents are never compared on a miss
localparam tlb_page_t NO_PAGE = '0;

// each line is {vpn2, odd_page, asid} then {found, index, page}
localparam search_case_t search_case_table [SEARCH_CASES] = '{
    '{'{19'h000, 1'b0, 8'h00}, '{1'b1, 4'h0, '{20'h00111, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h000, 1'b1, 8'h00}, '{1'b1, 4'h0, '{20'h00022, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h000, 1'b1, 8'h01}, '{1'b0, 4'h0, NO_PAGE}},
    // entries 1 and 3 are global, so any asid hits
    '{'{19'h111, 1'b1, 8'h00}, '{1'b1, 4'h1, '{20'h00033, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h111, 1'b0, 8'h01}, '{1'b1, 4'h1, '{20'h00222, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h222, 1'b0, 8'h00}, '{1'b0, 4'h0, NO_PAGE}},
    '{'{19'h222, 1'b0, 8'h02}, '{1'b1, 4'h2, '{20'h00333, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h333, 1'b0, 8'h03}, '{1'b1, 4'h3, '{20'h00444, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h333, 1'b1, 8'h04}, '{1'b1, 4'h3, '{20'h00055, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h444, 1'b0, 8'h04}, '{1'b1, 4'h4, '{20'h00555, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h444, 1'b0, 8'h05}, '{1'b0, 4'h0, NO_PAGE}},
    '{'{19'h555, 1'b1, 8'h05}, '{1'b1, 4'h5, '{20'h00077, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h666, 1'b0, 8'h06}, '{1'b1, 4'h6, '{20'h00777, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h666, 1'b1, 8'h07}, '{1'b0, 4'h0, NO_PAGE}},
    '{'{19'h666, 1'b1, 8'h08}, '{1'b0, 4'h0, NO_PAGE}},
    '{'{19'h777, 1'b0, 8'h07}, '{1'b1, 4'h7, '{20'h00888, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h888, 1'b0, 8'h08}, '{1'b1, 4'h8, '{20'h00999, 3'd3, 1'b1, 1'b1}}},
    '{'{19'h999, 1'b1, 8'h09}, '{1'b1, 4'h9, '{20'h000bb, 3'd3, 1'b1, 1'b1}}},
    '{'{19'haaa, 1'b0, 8'h0a}, '{1'b1, 4'ha, '{20'h00bbb, 3'd3, 1'b1, 1'b1}}},
    '{'{19'hbbb, 1'b1, 8'h0b}, '{1'b1, 4'hb, '{20'h000dd, 3'd3, 1'b1, 1'b1}}},
    '{'{19'hccc, 1'b0, 8'h0c}, '{1'b1, 4'hc, '{20'h00ddd, 3'd3, 1'b1, 1'b1}}},
    '{'{19'hddd, 1'b1, 8'h0d}, '{1'b1, 4'hd, '{20'h000ff, 3'd3, 1'b1, 1'b1}}},
    '{'{19'heee, 1'b0, 8'h0e}, '{1'b1, 4'he, '{20'h00fff, 3'd3, 1'b1, 1'b1}}},
    '{'{19'hfff, 1'b1, 8'h0f}, '{1'b1, 4'hf, '{20'h00011, 3'd3, 1'b1, 1'b1}}},
    // vpn2 values that no entry holds
    '{'{19'habc, 1'b0, 8'h0f}, '{1'b0, 4'h0, NO_PAGE}},
    '{'{19'h123, 1'b1, 8'h03}, '{1'b0, 4'h0, NO_PAGE}}
};

`endif

//--- src/tlb_test_pkg.sv
// TLB self-test definitions
package tlb_test_pkg;

    localparam int TLB_ENTRIES = 16;
    localparam int SEARCH_CASES = 26;
    localparam int SEARCH_STEPS = 13;
    localparam int SEARCH_PORTS = 2;

    typedef logic [$clog2(TLB_ENTRIES)-1:0] tlb_index_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [7:0] asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [3:0] search_step_t;
    typedef logic [4:0] case_id_t;

    typedef enum logic [1:0] {
        PH_WRITE,
        PH_VERIFY,
        PH_DONE
    } test_phase_e;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE,
        OP_VERIFY
    } tlb_op_e;

    typedef struct packed {
        pfn_t       pfn;
        logic [2:0] c;
        logic       d;
        logic       v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        vpn2_t vpn2;
        logic  odd_page;
        asid_t asid;
    } search_req_t;

    typedef struct packed {
        logic       found;
        tlb_index_t index;
        tlb_page_t  page;
    } search_rsp_t;

    typedef struct packed {
        search_req_t req;
        search_rsp_t rsp;
    } search_case_t;

    typedef struct packed {
        tlb_op_e      opcode;
        tlb_index_t   index;
        search_step_t step;
    } test_op_t;

    typedef struct packed {
        logic                           we;
        tlb_index_t                     w_index;
        tlb_entry_t                     w_entry;
        tlb_index_t                     r_index;
        search_req_t [SEARCH_PORTS-1:0] s_req;
        tlb_op_e                        op;
    } tlb_cmd_t;

    // index and step travel along so the checker can spot the final read and pair
    typedef struct packed {
        tlb_index_t                     r_index;
        search_step_t                   step;
        tlb_entry_t                     r_entry;
        search_rsp_t [SEARCH_PORTS-1:0] s_rsp;
    } tlb_expect_t;

    typedef struct packed {
        tlb_op_e                        op;
        tlb_entry_t                     r_entry;
        search_rsp_t [SEARCH_PORTS-1:0] s_rsp;
    } tlb_rsp_t;

    typedef struct packed {
        logic         test_error;
        logic         w_ok;
        logic         r_ok;
        logic         s_ok;
        tlb_index_t   w_cnt;
        tlb_index_t   r_cnt;
        search_step_t s_cnt;
    } test_status_t;

    // contents of entry i where only entries 1 and 3 are global
    function automatic tlb_entry_t entry_pattern(tlb_index_t i);
        tlb_entry_t e;
        tlb_index_t i1;
        tlb_index_t i2;
        i1 = tlb_index_t'(i + 1);
        i2 = tlb_index_t'(i + 2);
        e.vpn2 = vpn2_t'(i) * vpn2_t'(19'h111);
        e.asid = asid_t'(i);
        e.g = (i == tlb_index_t'(1)) || (i == tlb_index_t'(3));
        e.page0 = '{pfn: pfn_t'(i1) * pfn_t'(20'h111), c: 3'd3, d: 1'b1, v: 1'b1};
        e.page1 = '{pfn: pfn_t'(i2) * pfn_t'(20'h11), c: 3'd3, d: 1'b1, v: 1'b1};
        return e;
    endfunction

    `include "search_cases.svh"

endpackage

//--- src/test_sequencer.sv
// Test phase sequencer
module test_sequencer (
    input  logic                       clk_g,
    input  logic                       resetn,
    input  logic                       step,
    input  logic                       test_error,
    output tlb_test_pkg::test_op_t     op,
    output logic                       w_ok,
    output tlb_test_pkg::tlb_index_t   w_cnt,
    output tlb_test_pkg::tlb_index_t   r_cnt,
    output tlb_test_pkg::search_step_t s_cnt
);
    import tlb_test_pkg::*;

    localparam tlb_index_t LAST_INDEX = tlb_index_t'(TLB_ENTRIES - 1);
    localparam search_step_t LAST_STEP = search_step_t'(SEARCH_STEPS - 1);

    test_phase_e phase;
    logic        accept;

    // a step is taken only while there is work left and nothing has failed
    assign accept = step && !test_error && (phase != PH_DONE);

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            phase <= PH_WRITE;
            op <= '{opcode: OP_NONE, index: '0, step: '0};
            w_ok <= 1'b0;
            w_cnt <= '0;
            r_cnt <= '0;
            s_cnt <= '0;
        end else begin
            op <= '{opcode: OP_NONE, index: '0, step: '0};
            if (accept) begin
                case (phase)
                    PH_WRITE: begin
                        op <= '{opcode: OP_WRITE, index: w_cnt, step: '0};
                        // w_cnt stays on the last entry once it has been written
                        if (w_cnt == LAST_INDEX) begin
                            phase <= PH_VERIFY;
                            w_ok <= 1'b1;
                        end else begin
                            w_cnt <= w_cnt + 1'b1;
                        end
                    end
                    PH_VERIFY: begin
                        op <= '{opcode: OP_VERIFY, index: r_cnt, step: s_cnt};
                        if (r_cnt != LAST_INDEX) begin
                            r_cnt <= r_cnt + 1'b1;
                        end
                        // the last search pair repeats until the reads catch up
                        if (s_cnt != LAST_STEP) begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                        if ((r_cnt == LAST_INDEX) && (s_cnt == LAST_STEP)) begin
                            phase <= PH_DONE;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- src/pattern_stage.sv
// Command and expectation generator
module pattern_stage (
    input  logic                      clk_g,
    input  logic                      resetn,
    input  tlb_test_pkg::test_op_t    op,
    output tlb_test_pkg::tlb_cmd_t    cmd,
    output tlb_test_pkg::tlb_expect_t expect_q
);
    import tlb_test_pkg::*;

    tlb_cmd_t    cmd_d;
    tlb_expect_t exp_next;

    always_comb begin
        case_id_t id;
        cmd_d.op = op.opcode;
        cmd_d.we = (op.opcode == OP_WRITE);
        cmd_d.w_index = op.index;
        cmd_d.w_entry = entry_pattern(op.index);
        cmd_d.r_index = op.index;

        // the read back must return exactly what the write stored
        exp_next.r_index = op.index;
        exp_next.step = op.step;
        exp_next.r_entry = entry_pattern(op.index);

        // step n covers cases 2n and 2n+1, one per search port
        for (int p = 0; p < SEARCH_PORTS; p++) begin
            id = {op.step, p[0]};
            cmd_d.s_req[p] = search_case_table[id].req;
            exp_next.s_rsp[p] = search_case_table[id].rsp;
        end
    end

    always_ff @(posedge clk_g) begin
        cmd <= cmd_d;
        expect_q <= exp_next;
        if (!resetn) begin
            cmd.op <= OP_NONE;
            cmd.we <= 1'b0;
        end
    end

endmodule

//--- src/tlb.sv
// Sixteen-entry dual-search TLB
module tlb (
    input  logic                   clk_g,
    input  logic                   resetn,
    input  tlb_test_pkg::tlb_cmd_t cmd,
    output tlb_test_pkg::tlb_rsp_t rsp
);
    import tlb_test_pkg::*;

    tlb_entry_t                     entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]         match [SEARCH_PORTS];
    search_rsp_t [SEARCH_PORTS-1:0] s_rsp_d;

    always_ff @(posedge clk_g) begin
        if (cmd.we) begin
            entries[cmd.w_index] <= cmd.w_entry;
        end
    end

    // an entry matches on vpn2 and on asid, unless it is global
    always_comb begin
        for (int p = 0; p < SEARCH_PORTS; p++) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                match[p][i] = (entries[i].vpn2 == cmd.s_req[p].vpn2)
                              && (entries[i].g || (entries[i].asid == cmd.s_req[p].asid));
            end
        end
    end

    // the loop runs downwards so the lowest matching index is the one kept
    always_comb begin
        for (int p = 0; p < SEARCH_PORTS; p++) begin
            s_rsp_d[p].found = |match[p];
            s_rsp_d[p].index = '0;
            s_rsp_d[p].page = '0;
            for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
                if (match[p][i]) begin
                    s_rsp_d[p].index = tlb_index_t'(i);
                    s_rsp_d[p].page = cmd.s_req[p].odd_page ? entries[i].page1
                                                            : entries[i].page0;
                end
            end
        end
    end

    // read and search results leave together with the opcode that asked for them
    always_ff @(posedge clk_g) begin
        rsp.op <= cmd.op;
        rsp.r_entry <= entries[cmd.r_index];
        rsp.s_rsp <= s_rsp_d;
        if (!resetn) begin
            rsp.op <= OP_NONE;
        end
    end

endmodule

//--- src/result_checker.sv
// Response checker
module result_checker (
    input  logic                      clk_g,
    input  logic                      resetn,
    input  tlb_test_pkg::tlb_rsp_t    rsp,
    input  tlb_test_pkg::tlb_expect_t expect_q,
    output logic                      test_error,
    output logic                      r_ok,
    output logic                      s_ok
);
    import tlb_test_pkg::*;

    localparam tlb_index_t LAST_INDEX = tlb_index_t'(TLB_ENTRIES - 1);
    localparam search_step_t LAST_STEP = search_step_t'(SEARCH_STEPS - 1);

    tlb_expect_t             exp_d;
    logic                    verify;
    logic                    r_mismatch;
    logic [SEARCH_PORTS-1:0] s_mismatch;
    logic                    mismatch;

    // the expectation arrives one cycle ahead of the TLB response
    always_ff @(posedge clk_g) begin
        exp_d <= expect_q;
    end

    assign verify = (rsp.op == OP_VERIFY);
    assign r_mismatch = (rsp.r_entry != exp_d.r_entry);

    // on an expected miss the index and page are don't care
    always_comb begin
        for (int p = 0; p < SEARCH_PORTS; p++) begin
            s_mismatch[p] = (rsp.s_rsp[p].found != exp_d.s_rsp[p].found)
                            || (exp_d.s_rsp[p].found
                                && ((rsp.s_rsp[p].index != exp_d.s_rsp[p].index)
                                    || (rsp.s_rsp[p].page != exp_d.s_rsp[p].page)));
        end
    end

    assign mismatch = r_mismatch || (|s_mismatch);

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            test_error <= 1'b0;
            r_ok <= 1'b0;
            s_ok <= 1'b0;
        end else if (verify) begin
            if (mismatch) begin
                test_error <= 1'b1;
            end else if (!test_error) begin
                if (exp_d.r_index == LAST_INDEX) begin
                    r_ok <= 1'b1;
                end
                if (exp_d.step == LAST_STEP) begin
                    s_ok <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/tlb_test_top.sv
// TLB self-test top level
module tlb_test_top (
    input  logic                       clk_g,
    input  logic                       resetn,
    input  logic                       step,
    output tlb_test_pkg::test_status_t status
);
    import tlb_test_pkg::*;

    test_op_t     op;
    tlb_cmd_t     cmd;
    tlb_expect_t  expect_q;
    tlb_rsp_t     rsp;
    logic         test_error;
    logic         w_ok;
    logic         r_ok;
    logic         s_ok;
    tlb_index_t   w_cnt;
    tlb_index_t   r_cnt;
    search_step_t s_cnt;

    test_sequencer i_sequencer (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .step       (step),
        .test_error (test_error),
        .op         (op),
        .w_ok       (w_ok),
        .w_cnt      (w_cnt),
        .r_cnt      (r_cnt),
        .s_cnt      (s_cnt)
    );

    pattern_stage i_pattern (
        .clk_g    (clk_g),
        .resetn   (resetn),
        .op       (op),
        .cmd      (cmd),
        .expect_q (expect_q)
    );

    tlb i_tlb (
        .clk_g  (clk_g),
        .resetn (resetn),
        .cmd    (cmd),
        .rsp    (rsp)
    );

    result_checker i_checker (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .rsp        (rsp),
        .expect_q   (expect_q),
        .test_error (test_error),
        .r_ok       (r_ok),
        .s_ok       (s_ok)
    );

    assign status = '{
        test_error: test_error,
        w_ok:       w_ok,
        r_ok:       r_ok,
        s_ok:       s_ok,
        w_cnt:      w_cnt,
        r_cnt:      r_cnt,
        s_cnt:      s_cnt
    };

endmodule

//--- sim/tlb_test_assert.sv
// TLB self-test assertions
module tlb_test_assert (
    input logic                       clk_g,
    input logic                       resetn,
    input tlb_test_pkg::test_status_t status
);

    // reads and searches only run once every entry has been written
    a_ok_order: assert property (@(posedge clk_g) disable iff (!resetn)
        (status.r_ok || status.s_ok) |-> status.w_ok)
        else $error("r_ok or s_ok is set while w_ok is low");

    a_flags_hold: assert property (@(posedge clk_g) disable iff (!resetn)
        !$fell(status.w_ok) && !$fell(status.r_ok) && !$fell(status.s_ok)
        && !$fell(status.test_error))
        else $error("a status flag fell outside reset");

    a_counts_rise: assert property (@(posedge clk_g) disable iff (!resetn)
        (status.w_cnt >= $past(status.w_cnt)) && (status.r_cnt >= $past(status.r_cnt))
        && (status.s_cnt >= $past(status.s_cnt)))
        else $error("a step count decreased");

endmodule

//--- sim/tb_monitor.sv
// Status monitor and reference model
module tb_monitor (
    input  logic                       clk_g,
    input  logic                       resetn,
    input  logic                       step,
    input  tlb_test_pkg::test_status_t status,
    output int                         errors
);
    import tlb_test_pkg::*;

    localparam logic [3:0] LAST_ENTRY = 4'd15;
    localparam logic [3:0] LAST_PAIR = 4'd12;

    test_phase_e phase_m;
    logic [3:0]  w_cnt_m;
    logic [3:0]  r_cnt_m;
    logic [3:0]  s_cnt_m;
    logic        w_ok_m;
    logic        r_ok_m;
    logic        s_ok_m;
    logic [2:0]  r_pipe;
    logic [2:0]  s_pipe;
    logic        armed = 1'b0;
    logic        accepted;
    logic        verify_step;
    int          error_count = 0;

    assign errors = error_count;
    assign accepted = step && (phase_m != PH_DONE);
    assign verify_step = accepted && (phase_m == PH_VERIFY);

    task automatic compare_field(input string name, input int expected, input int actual);
        if (expected != actual) begin
            error_count = error_count + 1;
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // the ok flags follow the final read and the final search pair three edges later
    always @(posedge clk_g) begin
        if (!resetn) begin
            armed <= 1'b1;
            phase_m <= PH_WRITE;
            w_cnt_m <= '0;
            r_cnt_m <= '0;
            s_cnt_m <= '0;
            w_ok_m <= 1'b0;
            r_ok_m <= 1'b0;
            s_ok_m <= 1'b0;
            r_pipe <= '0;
            s_pipe <= '0;
        end else begin
            r_pipe <= {r_pipe[1:0], verify_step && (r_cnt_m == LAST_ENTRY)};
            s_pipe <= {s_pipe[1:0], verify_step && (s_cnt_m == LAST_PAIR)};
            r_ok_m <= r_ok_m | r_pipe[2];
            s_ok_m <= s_ok_m | s_pipe[2];
            if (accepted && (phase_m == PH_WRITE)) begin
                if (w_cnt_m == LAST_ENTRY) begin
                    phase_m <= PH_VERIFY;
                    w_ok_m <= 1'b1;
                end else begin
                    w_cnt_m <= w_cnt_m + 4'd1;
                end
            end
            if (verify_step) begin
                if (r_cnt_m != LAST_ENTRY) begin
                    r_cnt_m <= r_cnt_m + 4'd1;
                end
                if (s_cnt_m != LAST_PAIR) begin
                    s_cnt_m <= s_cnt_m + 4'd1;
                end
                if ((r_cnt_m == LAST_ENTRY) && (s_cnt_m == LAST_PAIR)) begin
                    phase_m <= PH_DONE;
                end
            end
        end
    end

    // status settles after the rising edge, so it is compared on the falling one
    always @(negedge clk_g) begin
        if (armed) begin
            compare_field("test_error", 0, int'(status.test_error));
            compare_field("w_ok", int'(w_ok_m), int'(status.w_ok));
            compare_field("r_ok", int'(r_ok_m), int'(status.r_ok));
            compare_field("s_ok", int'(s_ok_m), int'(status.s_ok));
            compare_field("w_cnt", int'(w_cnt_m), int'(status.w_cnt));
            compare_field("r_cnt", int'(r_cnt_m), int'(status.r_cnt));
            compare_field("s_cnt", int'(s_cnt_m), int'(status.s_cnt));
        end
    end

endmodule

//--- sim/tb_top.sv
// TLB self-test testbench
module tb_top;
    import tlb_test_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 4;
    localparam int PIPE_DEPTH = 3;
    localparam int TEST_STEPS = 2 * TLB_ENTRIES;
    localparam int TIMEOUT = 4 * TEST_STEPS * CLK_PERIOD
                             + (PIPE_DEPTH + RESET_CYCLES) * CLK_PERIOD;

    logic         clk_g = 1'b0;
    logic         resetn = 1'b0;
    logic         step = 1'b0;
    logic [31:0]  rng_state = 32'h752d;
    test_status_t status;
    int           value_errors;
    int           run_errors = 0;

    bind tlb_test_top tlb_test_assert i_assert (
        .clk_g  (clk_g),
        .resetn (resetn),
        .status (status)
    );

    always #(CLK_PERIOD / 2) clk_g = ~clk_g;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    tlb_test_top i_dut (
        .clk_g  (clk_g),
        .resetn (resetn),
        .step   (step),
        .status (status)
    );

    tb_monitor i_mon (
        .clk_g  (clk_g),
        .resetn (resetn),
        .step   (step),
        .status (status),
        .errors (value_errors)
    );

    // a quarter of the cycles carry no step, so the sequencer also sees idle edges
    always @(negedge clk_g) begin
        rng_state = xorshift32(rng_state);
        step = (rng_state[1:0] != 2'b00);
    end

    initial begin
        repeat (RESET_CYCLES) @(negedge clk_g);
        resetn = 1'b1;
        while (!(status.w_ok && status.r_ok && status.s_ok) && !status.test_error) begin
            @(negedge clk_g);
        end
        if (status.test_error) begin
            run_errors = run_errors + 1;
            $display("the DUT raised its error flag during the run");
        end
        // a few more cycles show that the counts stay frozen in the done phase
        repeat (8) @(negedge clk_g);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, run_errors);
        if ((value_errors == 0) && (run_errors == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the ok flags were not all set after %0d time units", TIMEOUT);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, run_errors + 1);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- src.f
+incdir+src
src/tlb_test_pkg.sv
src/test_sequencer.sv
src/pattern_stage.sv
src/tlb.sv
src/result_checker.sv
src/tlb_test_top.sv
sim/tlb_test_assert.sv
sim/tb_monitor.sv
sim/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the TLB self-test with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
